/* rtl/snn_macros.svh */
//****************************************
// network size and SPI frame width macros
//****************************************
`ifndef SNN_MACROS_SVH
`define SNN_MACROS_SVH

// network dimensions
`define SNN_NUM_INPUTS  8   // input spike lines
`define SNN_NUM_NEURONS 4   // LIF neurons in the single layer

// synapse fields
`define SNN_WEIGHT_W    4   // signed weight
`define SNN_DELAY_W     2   // delay 0..3 timesteps

// neuron state
`define SNN_POT_W       8   // signed membrane potential

// host interface
`define SNN_FRAME_W     16  // bits per SPI frame, MSB first

`endif

/* rtl/snn_pkg.sv */
//****************************************
// SPI frame union, network config and
// delayed tap bundle types
//****************************************
`include "snn_macros.svh"

package snn_pkg;

    // frame kind, top bit of every frame
    localparam logic KIND_SYN = 1'b0;  // synapse write
    localparam logic KIND_CFG = 1'b1;  // config register write

    // config register selects
    localparam logic [2:0] CFG_SEL_THRESH = 3'd0;
    localparam logic [2:0] CFG_SEL_LEAK   = 3'd1;
    localparam logic [2:0] CFG_SEL_DEBUG  = 3'd2;

    typedef struct packed {
        logic                                kind;    // KIND_SYN
        logic [$clog2(`SNN_NUM_NEURONS)-1:0] neuron;  // target neuron
        logic [$clog2(`SNN_NUM_INPUTS)-1:0]  src;     // source input line
        logic [`SNN_DELAY_W-1:0]             delay;
        logic signed [`SNN_WEIGHT_W-1:0]     weight;
        logic [3:0]                          rsvd;
    } syn_write_t;

    typedef struct packed {
        logic       kind;   // KIND_CFG
        logic [2:0] sel;    // CFG_SEL_*
        logic [3:0] rsvd;
        logic [7:0] value;
    } cfg_write_t;

    // one 16-bit word, read by its kind bit
    typedef union packed {
        syn_write_t syn;
        cfg_write_t cfg;
    } spi_frame_u;

    typedef struct packed {
        logic signed [`SNN_POT_W-1:0] threshold;   // fire when pot >= this
        logic [2:0]                   leak_shift;  // 0 means no leak
        logic [2:0]                   dbg_sel;     // debug bus source
    } net_cfg_t;

    typedef struct packed {
        logic                                                valid;  // one step
        logic [`SNN_NUM_NEURONS-1:0][`SNN_NUM_INPUTS-1:0]    tap;    // [neuron][input]
    } tap_bundle_t;

endpackage

/* rtl/spi_frontend.sv */
//****************************************
// SPI slave, synchronized to clk, frame
// receive and previous frame echo on MISO
//****************************************
`timescale 1ns/1ps
`include "snn_macros.svh"

module spi_frontend (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sclk,
    input  logic                mosi,
    input  logic                cs_n,
    output logic                miso,
    output snn_pkg::spi_frame_u frame,
    output logic                frame_valid
);

    localparam int FRAME_W = `SNN_FRAME_W;
    localparam int CNT_W   = $clog2(FRAME_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(FRAME_W - 1);

    logic [2:0]         sclk_q;      // 2 sync flops plus previous value
    logic [2:0]         cs_q;
    logic [1:0]         mosi_q;      // aligned with sclk_q[1]
    logic               sclk_rise;
    logic               sclk_fall;
    logic               cs_fall;
    logic               cs_active;
    logic [CNT_W-1:0]   bit_cnt;
    logic               frame_done;  // last bit just shifted in
    logic [FRAME_W-1:0] rx_sr;
    logic [FRAME_W-1:0] tx_sr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_q <= '0;
            cs_q   <= '1;  // deselected
            mosi_q <= '0;
        end else begin
            sclk_q <= {sclk_q[1:0], sclk};
            cs_q   <= {cs_q[1:0], cs_n};
            mosi_q <= {mosi_q[0], mosi};
        end
    end

    assign sclk_rise = sclk_q[1] & ~sclk_q[2];
    assign sclk_fall = ~sclk_q[1] & sclk_q[2];
    assign cs_fall   = ~cs_q[1] & cs_q[2];
    assign cs_active = ~cs_q[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (!cs_active) begin
                bit_cnt <= '0;  // partial frame dropped here
            end else if (sclk_rise) begin
                bit_cnt    <= bit_cnt + CNT_W'(1);  // wraps to 0 after last bit
                frame_done <= (bit_cnt == LAST_BIT);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs_active && sclk_rise)
            rx_sr <= {rx_sr[FRAME_W-2:0], mosi_q[1]};  // MSB first
    end

    // last complete frame, source of the MISO echo
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame       <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= frame_done;
            if (frame_done)
                frame <= rx_sr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_sr <= '0;
        end else if (cs_fall) begin
            tx_sr <= frame;                            // echo previous frame
        end else if (cs_active && sclk_fall) begin
            tx_sr <= {tx_sr[FRAME_W-2:0], 1'b0};       // next bit on falling edge
        end
    end

    assign miso = tx_sr[FRAME_W-1];

    // a 16-bit frame needs many clks, two pulses in a row mean a broken counter
    a_frame_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |=> !frame_valid);

endmodule

/* rtl/param_regs.sv */
//****************************************
// frame decode into weight, delay and
// network config registers
//****************************************
`timescale 1ns/1ps
`include "snn_macros.svh"

module param_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  snn_pkg::spi_frame_u frame,
    input  logic                frame_valid,
    output logic [`SNN_NUM_NEURONS-1:0][`SNN_NUM_INPUTS-1:0][`SNN_WEIGHT_W-1:0] weights,
    output logic [`SNN_NUM_NEURONS-1:0][`SNN_NUM_INPUTS-1:0][`SNN_DELAY_W-1:0]  delays,
    output snn_pkg::net_cfg_t   cfg,
    output logic                instr_done
);

    import snn_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weights    <= '0;
            delays     <= '0;
            cfg        <= '0;
            instr_done <= 1'b0;
        end else begin
            instr_done <= frame_valid;  // frame applied this clk
            if (frame_valid) begin
                unique case (frame.syn.kind)
                    KIND_SYN: begin
                        weights[frame.syn.neuron][frame.syn.src] <= frame.syn.weight;
                        delays[frame.syn.neuron][frame.syn.src]  <= frame.syn.delay;
                    end
                    KIND_CFG: begin
                        case (frame.cfg.sel)
                            CFG_SEL_THRESH: cfg.threshold  <= frame.cfg.value;
                            CFG_SEL_LEAK:   cfg.leak_shift <= frame.cfg.value[2:0];
                            CFG_SEL_DEBUG:  cfg.dbg_sel    <= frame.cfg.value[2:0];
                            default:        ;  // unknown select, frame ignored
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* rtl/spike_delay_line.sv */
//****************************************
// per-input spike history and delayed
// tap selection for every synapse
//****************************************
`timescale 1ns/1ps
`include "snn_macros.svh"

module spike_delay_line (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         step,
    input  logic [`SNN_NUM_INPUTS-1:0]   spikes_in,
    input  logic [`SNN_NUM_NEURONS-1:0][`SNN_NUM_INPUTS-1:0][`SNN_DELAY_W-1:0] delays,
    output snn_pkg::tap_bundle_t         taps
);

    localparam int NUM_IN  = `SNN_NUM_INPUTS;
    localparam int NUM_NEU = `SNN_NUM_NEURONS;
    localparam int DEPTH   = 1 << `SNN_DELAY_W;  // history incl. current step

    logic [DEPTH-2:0] hist      [NUM_IN];  // past steps only, [0] is last step
    logic [DEPTH-1:0] next_hist [NUM_IN];  // [0] is the current input

    always_comb begin
        for (int i = 0; i < NUM_IN; i++)
            next_hist[i] = {hist[i], spikes_in[i]};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_IN; i++)
                hist[i] <= '0;
        end else if (step) begin
            for (int i = 0; i < NUM_IN; i++)
                hist[i] <= next_hist[i][DEPTH-2:0];  // oldest drops out
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            taps <= '0;
        end else begin
            taps.valid <= step;
            if (step) begin
                for (int n = 0; n < NUM_NEU; n++)
                    for (int i = 0; i < NUM_IN; i++)
                        taps.tap[n][i] <= next_hist[i][delays[n][i]];  // d steps back
            end
        end
    end

endmodule

/* rtl/lif_neuron_layer.sv */
//****************************************
// leaky integrate-and-fire layer, four
// neurons, debug bus select
//****************************************
`timescale 1ns/1ps
`include "snn_macros.svh"

module lif_neuron_layer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  snn_pkg::tap_bundle_t taps,
    input  logic [`SNN_NUM_NEURONS-1:0][`SNN_NUM_INPUTS-1:0][`SNN_WEIGHT_W-1:0] weights,
    input  snn_pkg::net_cfg_t    cfg,
    output logic [7:0]           debug_output,
    output logic                 output_ready
);

    localparam int NUM_IN  = `SNN_NUM_INPUTS;
    localparam int NUM_NEU = `SNN_NUM_NEURONS;
    localparam int POT_W   = `SNN_POT_W;
    localparam int ACC_W   = POT_W + 2;  // headroom for pot - leak + sum
    localparam int IDX_W   = $clog2(NUM_NEU);
    localparam logic signed [ACC_W-1:0] POT_MAX = ACC_W'((1 << (POT_W - 1)) - 1);
    localparam logic signed [ACC_W-1:0] POT_MIN = -POT_MAX - ACC_W'(1);

    logic signed [POT_W-1:0]         pot     [NUM_NEU];  // membrane state
    logic signed [POT_W-1:0]         leak    [NUM_NEU];
    logic signed [ACC_W-1:0]         acc     [NUM_NEU];
    logic signed [POT_W-1:0]         pot_sat [NUM_NEU];
    logic signed [POT_W-1:0]         pot_nxt [NUM_NEU];  // after fire reset
    logic [NUM_NEU-1:0]              fire;
    logic signed [`SNN_WEIGHT_W-1:0] w_syn;
    logic [IDX_W-1:0]                dbg_idx;
    logic [7:0]                      dbg_nxt;

    always_comb begin
        w_syn = '0;
        for (int n = 0; n < NUM_NEU; n++) begin
            if (cfg.leak_shift == '0)
                leak[n] = '0;
            else
                leak[n] = pot[n] >>> cfg.leak_shift;  // arithmetic, keeps sign
            acc[n] = ACC_W'(pot[n]) - ACC_W'(leak[n]);
            for (int i = 0; i < NUM_IN; i++) begin
                w_syn = weights[n][i];
                if (taps.tap[n][i])
                    acc[n] = acc[n] + ACC_W'(w_syn);  // sign extended
            end
            if (acc[n] > POT_MAX)
                pot_sat[n] = POT_W'(POT_MAX);
            else if (acc[n] < POT_MIN)
                pot_sat[n] = POT_W'(POT_MIN);
            else
                pot_sat[n] = POT_W'(acc[n]);
            fire[n]    = (pot_sat[n] >= cfg.threshold);
            pot_nxt[n] = fire[n] ? '0 : pot_sat[n];
        end
    end

    // select 1..4 wraps onto neuron 0..3
    always_comb begin
        dbg_idx = cfg.dbg_sel[IDX_W-1:0] - IDX_W'(1);
        if (cfg.dbg_sel == 3'd0)
            dbg_nxt = {{(8 - NUM_NEU){1'b0}}, fire};  // spike vector
        else if (cfg.dbg_sel <= 3'(NUM_NEU))
            dbg_nxt = pot_nxt[dbg_idx];
        else
            dbg_nxt = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < NUM_NEU; n++)
                pot[n] <= '0;
            debug_output <= '0;
            output_ready <= 1'b0;
        end else begin
            output_ready <= taps.valid;
            if (taps.valid) begin
                for (int n = 0; n < NUM_NEU; n++)
                    pot[n] <= pot_nxt[n];
                debug_output <= dbg_nxt;  // held until next step
            end
        end
    end

    a_ready_after_taps: assert property (@(posedge clk) disable iff (!rst_n)
        output_ready |-> $past(taps.valid));

endmodule

/* rtl/spiking_network_top.sv */
//****************************************
// SPI, parameter, delay and neuron stages
//****************************************
`timescale 1ns/1ps
`include "snn_macros.svh"

module spiking_network_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       sclk,
    input  logic                       mosi,
    input  logic                       ss_n,
    input  logic                       input_ready,
    input  logic                       snn_en,
    input  logic [`SNN_NUM_INPUTS-1:0] input_spikes,
    output logic                       miso,
    output logic                       output_ready,
    output logic                       spi_instruction_done,
    output logic [7:0]                 debug_output
);

    import snn_pkg::*;

    spi_frame_u  frame;
    logic        frame_valid;
    logic [`SNN_NUM_NEURONS-1:0][`SNN_NUM_INPUTS-1:0][`SNN_WEIGHT_W-1:0] weights;
    logic [`SNN_NUM_NEURONS-1:0][`SNN_NUM_INPUTS-1:0][`SNN_DELAY_W-1:0]  delays;
    net_cfg_t    cfg;
    tap_bundle_t taps;
    logic        step;

    assign step = input_ready & snn_en;  // pulses with SNN_en low are dropped

    spi_frontend u_spi_frontend (
        .clk         (clk),
        .rst_n       (rst_n),
        .sclk        (sclk),
        .mosi        (mosi),
        .cs_n        (ss_n),
        .miso        (miso),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    param_regs u_param_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame       (frame),
        .frame_valid (frame_valid),
        .weights     (weights),
        .delays      (delays),
        .cfg         (cfg),
        .instr_done  (spi_instruction_done)
    );

    spike_delay_line u_spike_delay_line (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .spikes_in (input_spikes),
        .delays    (delays),
        .taps      (taps)
    );

    lif_neuron_layer u_lif_neuron_layer (
        .clk          (clk),
        .rst_n        (rst_n),
        .taps         (taps),
        .weights      (weights),
        .cfg          (cfg),
        .debug_output (debug_output),
        .output_ready (output_ready)
    );

endmodule

/* rtl/tt_um_snn_with_delays.sv */
//****************************************
// tiny-tapeout pin wrapper for the SNN
//****************************************
`timescale 1ns/1ps
`default_nettype none

module tt_um_snn_with_delays (
    input  wire [7:0] ui_in,    // input spikes
    output wire [7:0] uo_out,   // debug bus
    input  wire [7:0] uio_in,   // SPI and step control
    output wire [7:0] uio_out,  // MISO and status pulses
    output wire [7:0] uio_oe,   // 1 drives the pin
    input  wire       ena,      // always high when powered
    input  wire       clk,
    input  wire       rst_n     // low resets
);

    wire       miso;
    wire       output_ready;
    wire       spi_instruction_done;
    wire [7:0] debug_output;
    wire       unused_pins;

    spiking_network_top u_spiking_network_top (
        .clk                  (clk),
        .rst_n                (rst_n),
        .sclk                 (uio_in[3]),
        .mosi                 (uio_in[1]),
        .ss_n                 (uio_in[0]),  // CS, active low
        .input_ready          (uio_in[4]),
        .snn_en               (uio_in[6]),
        .input_spikes         (ui_in),
        .miso                 (miso),
        .output_ready         (output_ready),
        .spi_instruction_done (spi_instruction_done),
        .debug_output         (debug_output)
    );

    assign uo_out  = debug_output;
    assign uio_oe  = 8'b1010_0100;  // bits 2, 5, 7 are outputs
    assign uio_out = {spi_instruction_done, 1'b0, output_ready, 2'b00, miso, 2'b00};

    assign unused_pins = &{ena, uio_in[2], uio_in[5], uio_in[7], 1'b0};

endmodule

`default_nettype wire

/* tb/snn_checker.sv */
//****************************************
// pin-level SNN reference model, output
// and MISO compare with error count
//****************************************
`timescale 1ns/1ps
`include "snn_macros.svh"

module snn_checker (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] spikes,        // ui_in
    input  logic       cs_n,
    input  logic       mosi,
    input  logic       sclk,
    input  logic       input_ready,
    input  logic       snn_en,
    input  logic [7:0] debug_output,  // uo_out
    input  logic       miso,
    input  logic       output_ready,
    input  logic       instr_done,
    output int         error_count
);

    localparam int NUM_IN  = `SNN_NUM_INPUTS;
    localparam int NUM_NEU = `SNN_NUM_NEURONS;
    localparam int FRAME_W = `SNN_FRAME_W;

    int                 wt   [NUM_NEU][NUM_IN];  // signed weights
    int                 dl   [NUM_NEU][NUM_IN];  // delays 0..3
    int                 pot  [NUM_NEU];
    logic [3:0]         hist [NUM_IN];           // [0] is the current step
    int                 thr;
    int                 leak_sh;
    int                 dsel;
    logic [FRAME_W-1:0] rx;
    logic [FRAME_W-1:0] last_frame;              // what MISO echoes next
    logic [FRAME_W-1:0] echo;
    int                 bit_cnt;
    int                 pending;                 // frames taken, done not seen yet
    logic               cs_prev;
    logic               sclk_prev;
    logic               miso_due;
    logic               miso_exp;
    logic               rdy0;                    // step seen at this posedge
    logic               rdy1;                    // output_ready expected now
    logic [7:0]         dbg0;
    logic [7:0]         exp_dbg;                 // held between steps

    function automatic void reset_model();
        for (int n = 0; n < NUM_NEU; n++) begin
            pot[n] = 0;
            for (int i = 0; i < NUM_IN; i++) begin
                wt[n][i] = 0;
                dl[n][i] = 0;
            end
        end
        for (int i = 0; i < NUM_IN; i++)
            hist[i] = '0;
        thr        = 0;
        leak_sh    = 0;
        dsel       = 0;
        rx         = '0;
        last_frame = '0;  // zeros on MISO after reset
        echo       = '0;
        bit_cnt    = 0;
        pending    = 0;
        cs_prev    = 1'b1;
        sclk_prev  = 1'b0;
        miso_due   = 1'b0;
        miso_exp   = 1'b0;
        rdy0       = 1'b0;
        rdy1       = 1'b0;
        dbg0       = '0;
        exp_dbg    = '0;
    endfunction

    // bit 15 picks synapse or config layout
    function automatic void apply_frame(input logic [15:0] f);
        if (!f[15]) begin
            wt[f[14:13]][f[12:10]] = int'($signed(f[7:4]));
            dl[f[14:13]][f[12:10]] = int'(f[9:8]);
        end else begin
            case (f[14:12])
                3'd0:    thr     = int'($signed(f[7:0]));
                3'd1:    leak_sh = int'(f[2:0]);
                3'd2:    dsel    = int'(f[2:0]);
                default: ;  // unknown select
            endcase
        end
    endfunction

    // reference step, returns the expected debug byte
    function automatic logic [7:0] ref_step(input logic [7:0] sp);
        int         sum;
        int         nxt;
        int         lk;
        logic [3:0] fired;
        logic [7:0] res;
        fired = '0;
        for (int i = 0; i < NUM_IN; i++)
            hist[i] = {hist[i][2:0], sp[i]};
        for (int n = 0; n < NUM_NEU; n++) begin
            lk  = (leak_sh == 0) ? 0 : (pot[n] >>> leak_sh);
            sum = 0;
            for (int i = 0; i < NUM_IN; i++)
                if (hist[i][dl[n][i]])
                    sum += wt[n][i];
            nxt = pot[n] - lk + sum;
            if (nxt > 127)
                nxt = 127;
            else if (nxt < -128)
                nxt = -128;
            fired[n] = (nxt >= thr);
            pot[n]   = fired[n] ? 0 : nxt;  // fire and reset
        end
        if (dsel == 0)
            res = {4'h0, fired};
        else if (dsel <= NUM_NEU)
            res = 8'(pot[dsel-1]);
        else
            res = '0;
        return res;
    endfunction

    function automatic void track_spi();
        if (cs_prev && !cs_n) begin
            echo    = last_frame;
            bit_cnt = 0;
        end
        if (!cs_prev && cs_n)
            bit_cnt = 0;  // cut frame dropped
        if (!cs_n && sclk && !sclk_prev) begin
            miso_exp = echo[FRAME_W-1-bit_cnt];
            miso_due = 1'b1;
            rx       = {rx[FRAME_W-2:0], mosi};
            bit_cnt++;
            if (bit_cnt == FRAME_W) begin
                apply_frame(rx);
                last_frame = rx;
                pending++;
                bit_cnt = 0;
            end
        end
        cs_prev   = cs_n;
        sclk_prev = sclk;
    endfunction

    function automatic void compare_pin(input string name, input logic [7:0] got,
                                        input logic [7:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s: got 0x%h expected 0x%h at %0t ns", name, got, exp, $time);
        end
    endfunction

    // inputs taken at posedge, outputs compared at negedge
    initial begin
        error_count = 0;
        reset_model();
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                reset_model();
            end else begin
                track_spi();
                rdy1 = rdy0;
                if (rdy0)
                    exp_dbg = dbg0;
                rdy0 = input_ready & snn_en;
                if (rdy0)
                    dbg0 = ref_step(spikes);
            end
            @(negedge clk);
            if (rst_n) begin
                compare_pin("output_ready", {7'b0, output_ready}, {7'b0, rdy1});
                compare_pin("debug_output", debug_output, exp_dbg);
                if (miso_due)
                    compare_pin("miso", {7'b0, miso}, {7'b0, miso_exp});
                miso_due = 1'b0;
                if (instr_done && pending == 0) begin
                    error_count++;
                    $display("spi_instruction_done pulsed without a completed frame at %0t ns",
                             $time);
                end else if (instr_done) begin
                    pending--;
                end
            end
        end
    end

endmodule

/* tb/tb_snn.sv */
//****************************************
// testbench top, clock, reset, SPI host,
// spike stimulus and watchdog
//****************************************
`timescale 1ns/1ps
`include "snn_macros.svh"

module tb_snn;

    localparam int FRAME_W   = `SNN_FRAME_W;
    localparam int N_FRAMES  = 70;    // frames sent below, rounded up
    localparam int N_STEPS   = 210;   // steps sent below, rounded up
    localparam int WDOG_CLKS = N_FRAMES * (FRAME_W * 8 + 16) + N_STEPS * 4 + 200;

    logic        clk;
    logic        rst_n;
    logic [7:0]  ui_in;
    logic [7:0]  uio_in;
    logic        ena;
    wire  [7:0]  uo_out;
    wire  [7:0]  uio_out;
    wire  [7:0]  uio_oe;
    int          seed;
    int          tb_errors;
    int          chk_errors;
    int          ready_cnt;
    int          ready_before;
    logic [31:0] rnd;
    int          thr_set  [4] = '{30, 12, -6, 127};
    int          leak_set [4] = '{1, 3, 2, 0};      // last one saturates
    logic [5:0]  en_pattern   = 6'b100111;          // bit k is SNN_en on clk k

    always #4 clk = ~clk;  // 8 ns period

    tt_um_snn_with_delays u_tt_um_snn_with_delays (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    snn_checker u_snn_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .spikes       (ui_in),
        .cs_n         (uio_in[0]),
        .mosi         (uio_in[1]),
        .sclk         (uio_in[3]),
        .input_ready  (uio_in[4]),
        .snn_en       (uio_in[6]),
        .debug_output (uo_out),
        .miso         (uio_out[2]),
        .output_ready (uio_out[5]),
        .instr_done   (uio_out[7]),
        .error_count  (chk_errors)
    );

    always @(negedge clk) begin
        if (rst_n && uio_out[5])
            ready_cnt <= ready_cnt + 1;
    end

    function automatic logic [15:0] syn_word(input int n, input int i, input int d,
                                             input int w);
        return {1'b0, 2'(n), 3'(i), 2'(d), 4'(w), 4'h0};
    endfunction

    function automatic logic [15:0] cfg_word(input int sel, input int val);
        return {1'b1, 3'(sel), 4'h0, 8'(val)};
    endfunction

    function automatic void expect_byte(input string name, input logic [7:0] got,
                                        input logic [7:0] exp);
        if (got !== exp) begin
            tb_errors++;
            $display("FAIL %s: got 0x%h expected 0x%h at %0t ns", name, got, exp, $time);
        end
    endfunction

    // starts and ends on a falling edge, 4 clks per SCLK half period
    task automatic send_frame(input logic [15:0] f, input int nbits);
        int wait_clks;
        uio_in[0] = 1'b0;
        repeat (2) @(negedge clk);
        for (int b = 0; b < nbits; b++) begin
            uio_in[1] = f[FRAME_W-1-b];  // MSB first
            repeat (4) @(negedge clk);
            uio_in[3] = 1'b1;
            repeat (4) @(negedge clk);
            uio_in[3] = 1'b0;
        end
        if (nbits == FRAME_W) begin
            wait_clks = 0;
            while (!uio_out[7] && wait_clks < 16) begin
                @(negedge clk);
                wait_clks++;
            end
            if (!uio_out[7]) begin
                tb_errors++;
                $display("no spi_instruction_done after frame 0x%h", f);
            end
        end
        uio_in[0] = 1'b1;  // cut frames end here too
        repeat (4) @(negedge clk);
    endtask

    task automatic do_step(input logic [7:0] sp, input logic en);
        int wait_clks;
        ui_in     = sp;
        uio_in[6] = en;
        uio_in[4] = 1'b1;
        @(negedge clk);
        uio_in[4] = 1'b0;
        wait_clks = 0;
        while (en && !uio_out[5] && wait_clks < 8) begin
            @(negedge clk);
            wait_clks++;
        end
        if (en && !uio_out[5]) begin
            tb_errors++;
            $display("output_ready never followed a step with SNN_en high");
        end
        if (!en)
            repeat (3) @(negedge clk);
        @(negedge clk);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        ui_in     = '0;
        uio_in    = 8'h01;  // CS idle high
        ena       = 1'b1;
        seed      = 29;
        tb_errors = 0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        expect_byte("uo_out", uo_out, 8'h00);
        expect_byte("uio_out", uio_out, 8'h00);
        expect_byte("uio_oe", uio_oe, 8'hA4);
        do_step(8'hFF, 1'b1);  // zero weights, threshold 0 so all fire

        // threshold, then a cut synapse write that must not land
        send_frame(cfg_word(0, 4), FRAME_W);
        send_frame(syn_word(0, 0, 0, 7), 12);
        do_step(8'h01, 1'b1);
        expect_byte("debug_output", uo_out, 8'h00);

        // neuron d hears input d with delay d
        for (int d = 0; d < 4; d++)
            send_frame(syn_word(d, d, d, 7), FRAME_W);
        for (int d = 0; d < 4; d++) begin
            for (int k = 0; k < 4; k++)
                do_step(8'h00, 1'b1);  // flush history
            for (int k = 0; k < 5; k++) begin
                do_step((k == 0) ? 8'(1 << d) : 8'h00, 1'b1);
                expect_byte("debug_output", uo_out, (k == d) ? 8'(1 << d) : 8'h00);
            end
        end

        // random weights incl. negative ones
        for (int n = 0; n < 4; n++) begin
            for (int i = 0; i < 8; i++) begin
                rnd = $random(seed);
                send_frame(syn_word(n, i, int'(rnd[1:0]), int'(rnd[7:4])), FRAME_W);
            end
        end
        for (int c = 0; c < 4; c++) begin
            send_frame(cfg_word(0, thr_set[c]), FRAME_W);
            send_frame(cfg_word(1, leak_set[c]), FRAME_W);
            for (int s = 0; s <= 4; s++) begin
                send_frame(cfg_word(2, s), FRAME_W);
                for (int k = 0; k < 8; k++) begin
                    rnd = $random(seed);
                    do_step((c == 3) ? 8'hFF : rnd[7:0], 1'b1);
                end
            end
        end

        // back-to-back pulses, two of them with SNN_en low
        send_frame(cfg_word(2, 6), FRAME_W);  // debug select out of range
        ready_before = ready_cnt;
        do_step(8'hFF, 1'b0);  // lone pulse, SNN_en low
        for (int k = 0; k < 6; k++) begin
            rnd       = $random(seed);
            ui_in     = rnd[7:0];
            uio_in[6] = en_pattern[k];
            uio_in[4] = 1'b1;
            @(negedge clk);
        end
        uio_in[4] = 1'b0;
        repeat (6) @(negedge clk);
        expect_byte("output_ready count", 8'(ready_cnt - ready_before), 8'd4);

        repeat (4) @(negedge clk);
        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WDOG_CLKS) @(posedge clk);
        $display("watchdog: run did not finish within %0d clks, errors: checker %0d, testbench %0d",
                 WDOG_CLKS, chk_errors, tb_errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* all.f */
+incdir+rtl
rtl/snn_pkg.sv
rtl/spi_frontend.sv
rtl/param_regs.sv
rtl/spike_delay_line.sv
rtl/lif_neuron_layer.sv
rtl/spiking_network_top.sv
rtl/tt_um_snn_with_delays.sv
tb/snn_checker.sv
tb/tb_snn.sv

/* Makefile */
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing -Wall
TOP       ?= tb_snn
FILELIST  ?= all.f
LOG       ?= sim.log
FAIL_MSG  := TEST RESULT: FAIL

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with $(SIM), run it into $(LOG) and check for failure"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
